/* source/controlPkg.sv */
package controlPkg;

	typedef logic [5:0] opcode_t;                  // Instruction bits 31..26
	typedef logic [5:0] funct_t;                   // R-type bits 5..0

	// Opcodes of the kept instructions
	localparam opcode_t opRType = 6'b000000;       // Dispatch on funct
	localparam opcode_t opBeq   = 6'b000100;
	localparam opcode_t opBne   = 6'b000101;
	localparam opcode_t opAddi  = 6'b001000;
	localparam opcode_t opAddiu = 6'b001001;
	localparam opcode_t opSlti  = 6'b001010;
	localparam opcode_t opOri   = 6'b001101;
	localparam opcode_t opLui   = 6'b001111;
	localparam opcode_t opLw    = 6'b100011;
	localparam opcode_t opSw    = 6'b101011;

	localparam funct_t fnSll  = 6'b000000;         // Shift by shamt
	localparam funct_t fnMult = 6'b011000;

	// Codes understood by the datapath ALU
	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,                             // Branch compare
		aluMul = 4'd2,
		aluOr  = 4'd6,
		aluLui = 4'd7,                             // Immediate to upper half
		aluSll = 4'd8,
		aluSlt = 4'd9
	} aluOp_t;

	typedef enum logic [3:0] {
		kindLui, kindOri, kindAddi, kindAddiu, kindSlti,
		kindLw, kindSw, kindBeq, kindBne, kindSll, kindMult,
		kindBadFunct,                              // Opcode zero, unknown funct
		kindIllegal                                // Unknown opcode
	} instrKind_t;

	typedef enum logic [3:0] {
		phFetch, phDecode, phRDispatch, phExecute, phMemAccess,
		phMemData, phWriteBack, phWriteBackExt, phBranchPc
	} phase_t;

	typedef enum logic [1:0] {dstRt = 2'd0, dstRd = 2'd1} regDst_t;
	typedef enum logic [1:0] {fromAlu = 2'd0, fromMem = 2'd1} memToReg_t;
	typedef enum logic [1:0] {
		srcBReg = 2'd0, srcBFour = 2'd1, srcBImm = 2'd2, srcBBranch = 2'd3
	} aluSrcB_t;

	// Datapath enables and selects, all zero when idle
	typedef struct packed {
		logic      pcWrite;
		logic      iorD;                           // Memory address from ALUOut
		logic      memWrite;
		logic      irWrite;
		logic      dataLoad;                       // Memory data register
		logic      regWrite;
		logic      regALoad;
		logic      regBLoad;
		logic      aluOutLoad;
		regDst_t   regDst;
		memToReg_t memToReg;
		logic      aluSrcA;                        // High picks register A
		aluSrcB_t  aluSrcB;
		aluOp_t    aluOp;
		logic      beqBranch;
		logic      bneBranch;
	} ctrlWord_t;

endpackage

/* source/instrDecoder.sv */
module instrDecoder
	import controlPkg::*;
(
	input  opcode_t    op,
	input  funct_t     funct,
	output instrKind_t kind
);

	always_comb
	begin
		case (op)
			opLui:   kind = kindLui;
			opOri:   kind = kindOri;
			opAddi:  kind = kindAddi;
			opAddiu: kind = kindAddiu;
			opSlti:  kind = kindSlti;
			opLw:    kind = kindLw;
			opSw:    kind = kindSw;
			opBeq:   kind = kindBeq;
			opBne:   kind = kindBne;
			opRType:
			begin
				// R-type picks the operation from funct
				case (funct)
					fnSll:   kind = kindSll;
					fnMult:  kind = kindMult;
					default: kind = kindBadFunct;  // Jr and the rest land here
				endcase
			end
			default: kind = kindIllegal;           // Jumps included
		endcase
	end

endmodule

/* source/controlSequencer.sv */
module controlSequencer
	import controlPkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  instrKind_t kind,
	output phase_t     phase,
	output instrKind_t heldKind
);

	phase_t nextPhase;                             // Phase for the coming cycle

	// Phase register and the kind held for the rest of the instruction
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			phase    <= phFetch;                   // Fetch word out during reset
			heldKind <= kindIllegal;
		end
		else
		begin
			phase <= nextPhase;
			if (phase == phDecode)
				heldKind <= kind;                  // IR is stable by now
		end
	end

	always_comb
	begin
		case (phase)
			phFetch:
				nextPhase = phDecode;
			phDecode:
			begin
				// heldKind is still stale here, use the live decode
				case (kind)
					kindSll, kindMult, kindBadFunct: nextPhase = phRDispatch;
					kindIllegal:                     nextPhase = phFetch;
					default:                         nextPhase = phExecute;
				endcase
			end
			phRDispatch:
			begin
				if (heldKind == kindSll || heldKind == kindMult)
					nextPhase = phExecute;
				else
					nextPhase = phFetch;           // Unknown funct ends here
			end
			phExecute:
			begin
				case (heldKind)
					kindLw, kindSw:   nextPhase = phMemAccess;
					kindBeq, kindBne: nextPhase = phBranchPc;
					default:          nextPhase = phWriteBack;
				endcase
			end
			phMemAccess:
			begin
				if (heldKind == kindLw)
					nextPhase = phMemData;         // Load needs the data cycle
				else
					nextPhase = phFetch;           // Store done
			end
			phMemData:
				nextPhase = phWriteBack;
			phWriteBack:
				nextPhase = phWriteBackExt;        // Second write cycle
			phWriteBackExt:
				nextPhase = phFetch;
			phBranchPc:
				nextPhase = phFetch;
			default:
				nextPhase = phFetch;               // Recover from a bad encoding
		endcase
	end

	// Phase register never leaves the defined encodings
	phaseDefined: assert property (@(posedge clk) disable iff (!reset)
		phase inside {phFetch, phDecode, phRDispatch, phExecute, phMemAccess,
			phMemData, phWriteBack, phWriteBackExt, phBranchPc})
	else
		$error("phase left the defined set: %0h", phase);

	// Store ends at the memory cycle, load goes on to read data
	memAccessExit: assert property (@(posedge clk) disable iff (!reset)
		phase == phMemAccess |=> phase inside {phFetch, phMemData})
	else
		$error("phMemAccess followed by %0h", phase);

endmodule

/* source/controlWordTable.sv */
module controlWordTable
	import controlPkg::*;
(
	input  phase_t     phase,
	input  instrKind_t heldKind,
	output ctrlWord_t  ctrl
);

	logic rTypeDst;                                // Result goes to rd
	logic loadData;                                // Writeback from memory

	assign rTypeDst = (heldKind == kindSll) || (heldKind == kindMult);
	assign loadData = (heldKind == kindLw);

	always_comb
	begin
		ctrl = '0;                                 // Idle unless set below
		case (phase)
			phFetch:
			begin
				ctrl.pcWrite  = 1'b1;              // PC + 4
				ctrl.irWrite  = 1'b1;
				ctrl.aluSrcB  = srcBFour;
				ctrl.aluOp    = aluAdd;
			end
			phDecode:
			begin
				ctrl.regALoad = 1'b1;              // rs
				ctrl.regBLoad = 1'b1;              // rt
			end
			phExecute:
			begin
				ctrl.aluSrcA = 1'b1;
				case (heldKind)
					kindLui, kindOri, kindAddi, kindAddiu, kindSlti, kindLw, kindSw:
					begin
						// Register A against sign extended immediate
						ctrl.aluSrcB    = srcBImm;
						ctrl.aluOutLoad = 1'b1;
						ctrl.regDst     = dstRt;
						case (heldKind)
							kindLui:  ctrl.aluOp = aluLui;
							kindOri:  ctrl.aluOp = aluOr;
							kindSlti: ctrl.aluOp = aluSlt;
							default:  ctrl.aluOp = aluAdd;  // Also address calc
						endcase
					end
					kindSll, kindMult:
					begin
						ctrl.aluSrcB    = srcBReg;
						ctrl.aluOutLoad = 1'b1;
						ctrl.regDst     = dstRd;
						if (heldKind == kindSll)
							ctrl.aluOp = aluSll;
						else
							ctrl.aluOp = aluMul;
					end
					kindBeq, kindBne:
					begin
						ctrl.aluSrcB = srcBReg;    // Compare A with B
						ctrl.aluOp   = aluSub;
					end
					default:
						ctrl.aluSrcA = 1'b0;       // Kind never executes
				endcase
			end
			phMemAccess:
			begin
				ctrl.iorD = 1'b1;                  // Address from ALUOut
				if (heldKind == kindSw)
					ctrl.memWrite = 1'b1;
				else
					ctrl.dataLoad = 1'b1;
			end
			phWriteBack, phWriteBackExt:
			begin
				// Both cycles drive the same destination and source
				ctrl.regWrite = 1'b1;
				ctrl.regDst   = rTypeDst ? dstRd : dstRt;
				ctrl.memToReg = loadData ? fromMem : fromAlu;
			end
			phBranchPc:
			begin
				ctrl.pcWrite   = 1'b1;             // Taken only if flag agrees
				ctrl.aluSrcB   = srcBBranch;
				ctrl.aluOp     = aluAdd;
				ctrl.beqBranch = (heldKind == kindBeq);
				ctrl.bneBranch = (heldKind == kindBne);
			end
			default:
				ctrl = '0;                         // RDispatch and MemData
		endcase
	end

	// Checked after the word settles for a phase and kind
	always_comb
	begin
		if (ctrl.memWrite)
			storeAddr: assert (ctrl.iorD)
			else
				$error("memWrite without iorD in phase %0h", phase);
		branchFlags: assert (!(ctrl.beqBranch && ctrl.bneBranch))
		else
			$error("both branch flags high, kind %0h", heldKind);
	end

endmodule

/* source/multicycleControl.sv */
module multicycleControl
	import controlPkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  opcode_t   op,
	input  funct_t    funct,
	output ctrlWord_t ctrl
);

	instrKind_t kind;                              // Live decode of the IR
	instrKind_t heldKind;                          // Latched in decode
	phase_t     phase;

	instrDecoder u_decoder (
		.op       (op),
		.funct    (funct),
		.kind     (kind)
	);

	controlSequencer u_sequencer (
		.clk      (clk),
		.reset    (reset),
		.kind     (kind),
		.phase    (phase),
		.heldKind (heldKind)
	);

	controlWordTable u_wordTable (
		.phase    (phase),
		.heldKind (heldKind),
		.ctrl     (ctrl)
	);

endmodule

/* sim/controlModel.svh */
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

// Cycles from fetch to the last phase of each kind
function automatic int instrLength(input instrKind_t k);
	case (k)
		kindSll, kindMult:         return 6;
		kindLw:                    return 7;
		kindSw, kindBeq, kindBne:  return 4;
		kindBadFunct:              return 3;
		kindIllegal:               return 2;
		default:                   return 5;   // I-type ALU group
	endcase
endfunction

// Phase that a kind is in at a given cycle of its instruction
function automatic phase_t phaseAt(input instrKind_t k, input int idx);
	phase_t rSeq[6];
	phase_t lwSeq[7];
	phase_t iSeq[5];
	rSeq  = '{phFetch, phDecode, phRDispatch, phExecute, phWriteBack, phWriteBackExt};
	lwSeq = '{phFetch, phDecode, phExecute, phMemAccess, phMemData, phWriteBack,
		phWriteBackExt};
	iSeq  = '{phFetch, phDecode, phExecute, phWriteBack, phWriteBackExt};
	if (idx == 0)
		return phFetch;
	case (k)
		kindSll, kindMult, kindBadFunct: return rSeq[idx];
		kindLw, kindSw:                  return lwSeq[idx];   // Store stops at MemAccess
		kindBeq, kindBne:
			return (idx == 1) ? phDecode : ((idx == 2) ? phExecute : phBranchPc);
		kindIllegal:                     return phDecode;
		default:                         return iSeq[idx];
	endcase
endfunction

// Control word required by the rules for a kind and cycle
function automatic ctrlWord_t expectedWord(input instrKind_t k, input int idx);
	ctrlWord_t w;
	logic rDst;
	rDst = (k == kindSll) || (k == kindMult);
	w = '0;
	case (phaseAt(k, idx))
		phFetch:
		begin
			w.pcWrite = 1'b1;
			w.irWrite = 1'b1;
			w.aluSrcB = srcBFour;
		end
		phDecode:
		begin
			w.regALoad = 1'b1;
			w.regBLoad = 1'b1;
		end
		phExecute:
		begin
			w.aluSrcA = 1'b1;
			w.aluOutLoad = !(k == kindBeq || k == kindBne);   // Branches only compare
			w.aluSrcB = (rDst || k == kindBeq || k == kindBne) ? srcBReg : srcBImm;
			w.regDst = rDst ? dstRd : dstRt;
			case (k)
				kindLui:          w.aluOp = aluLui;
				kindOri:          w.aluOp = aluOr;
				kindSlti:         w.aluOp = aluSlt;
				kindSll:          w.aluOp = aluSll;
				kindMult:         w.aluOp = aluMul;
				kindBeq, kindBne: w.aluOp = aluSub;
				default:          w.aluOp = aluAdd;
			endcase
		end
		phMemAccess:
		begin
			w.iorD = 1'b1;
			w.memWrite = (k == kindSw);
			w.dataLoad = (k == kindLw);
		end
		phWriteBack, phWriteBackExt:
		begin
			w.regWrite = 1'b1;
			w.regDst = rDst ? dstRd : dstRt;
			w.memToReg = (k == kindLw) ? fromMem : fromAlu;
		end
		phBranchPc:
		begin
			w.pcWrite = 1'b1;
			w.aluSrcB = srcBBranch;
			w.beqBranch = (k == kindBeq);
			w.bneBranch = (k == kindBne);
		end
		default:
			w = '0;                         // Dispatch and memory data cycles idle
	endcase
	return w;
endfunction

// Galois LFSR, 16 bits, one step per bit taken
function automatic logic [15:0] lfsrStep(input logic [15:0] s);
	return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

`endif

/* sim/tbMulticycleControl.sv */
module tbMulticycleControl
	import controlPkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	`include "controlModel.svh"

	localparam int numInstr = 80;                  // First 13 walk every kind

	logic       clk = 1'b0;
	logic       reset;
	opcode_t    op;
	funct_t     funct;
	ctrlWord_t  ctrl;
	instrKind_t curKind;                           // Instruction now in flight
	int         curIdx;                            // Cycle within it
	logic [15:0] lfsr = 16'd58784;
	int         valueErrors = 0;
	int         timeouts = 0;

	multicycleControl u_dut (
		.clk   (clk),
		.reset (reset),
		.op    (op),
		.funct (funct),
		.ctrl  (ctrl)
	);

	always #20 clk = ~clk;                         // 40 ns period

	task automatic drawBits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			v = v * 2 + int'(lfsr[0]);
			lfsr = lfsrStep(lfsr);
		end
	endtask

	function automatic opcode_t opFor(input instrKind_t k, input int sel);
		opcode_t badOps[4];
		badOps = '{6'h02, 6'h03, 6'h3F, 6'h10};    // Jumps and unused codes
		case (k)
			kindLui:   return opLui;
			kindOri:   return opOri;
			kindAddi:  return opAddi;
			kindAddiu: return opAddiu;
			kindSlti:  return opSlti;
			kindLw:    return opLw;
			kindSw:    return opSw;
			kindBeq:   return opBeq;
			kindBne:   return opBne;
			kindIllegal: return badOps[sel];
			default:   return opRType;
		endcase
	endfunction

	function automatic funct_t functFor(input instrKind_t k, input int sel, input int fn);
		funct_t badFns[4];
		badFns = '{6'h08, 6'h20, 6'h02, 6'h3F};    // Jr, add and others
		case (k)
			kindSll:      return fnSll;
			kindMult:     return fnMult;
			kindBadFunct: return badFns[sel];
			default:      return funct_t'(fn);     // Ignored by the decoder
		endcase
	endfunction

	task automatic checkField(input string name, input logic [3:0] got,
		input logic [3:0] want);
		if (got !== want)
		begin
			valueErrors++;
			$display("ERROR: %s got %h expected %h (kind %0d, cycle %0d)",
				name, got, want, curKind, curIdx);
		end
	endtask

	// Compare every cycle mid-period, away from the driving edge
	always @(negedge clk)
	begin
		ctrlWord_t w;
		w = expectedWord(curKind, curIdx);
		checkField("pcWrite", ctrl.pcWrite, w.pcWrite);
		checkField("iorD", ctrl.iorD, w.iorD);
		checkField("memWrite", ctrl.memWrite, w.memWrite);
		checkField("irWrite", ctrl.irWrite, w.irWrite);
		checkField("dataLoad", ctrl.dataLoad, w.dataLoad);
		checkField("regWrite", ctrl.regWrite, w.regWrite);
		checkField("regALoad", ctrl.regALoad, w.regALoad);
		checkField("regBLoad", ctrl.regBLoad, w.regBLoad);
		checkField("aluOutLoad", ctrl.aluOutLoad, w.aluOutLoad);
		checkField("regDst", ctrl.regDst, w.regDst);
		checkField("memToReg", ctrl.memToReg, w.memToReg);
		checkField("aluSrcA", ctrl.aluSrcA, w.aluSrcA);
		checkField("aluSrcB", ctrl.aluSrcB, w.aluSrcB);
		checkField("aluOp", ctrl.aluOp, w.aluOp);
		checkField("beqBranch", ctrl.beqBranch, w.beqBranch);
		checkField("bneBranch", ctrl.bneBranch, w.bneBranch);
	end

	task automatic waitForFetch(output bit ok);
		int waited;
		ctrlWord_t fetchWord;
		fetchWord = expectedWord(kindIllegal, 0);
		waited = 0;
		ok = 1'b0;
		while (!ok && waited < 8)
		begin
			@(negedge clk);
			waited++;
			if (ctrl == fetchWord)
				ok = 1'b1;
		end
		if (!ok)
		begin
			timeouts++;
			$display("Timeout: no fetch word within 8 cycles after kind %0d", curKind);
		end
	endtask

	// Drive op and funct at the end of fetch, then track the cycle index
	task automatic runInstr(input instrKind_t k, output bit ok);
		int sel;
		int fn;
		int len;
		drawBits(2, sel);
		drawBits(6, fn);
		len = instrLength(k);
		@(posedge clk);
		op      <= opFor(k, sel);
		funct   <= functFor(k, sel, fn);
		curKind <= k;
		curIdx  <= 1;
		for (int i = 2; i < len; i++)
		begin
			@(posedge clk);
			curIdx <= i;
		end
		@(posedge clk);
		curIdx <= 0;                               // Back to fetch
		waitForFetch(ok);
	endtask

	initial
	begin
		int n;
		int v;
		bit ok;
		instrKind_t k;
		reset   = 1'b0;
		op      = '0;
		funct   = '0;
		curKind = kindIllegal;
		curIdx  = 0;                               // Fetch word during reset
		repeat (3) @(posedge clk);
		reset <= 1'b1;
		@(negedge clk);
		n = 0;
		ok = 1'b1;
		while (ok && n < numInstr)
		begin
			if (n < 13)
				k = instrKind_t'(n);
			else
			begin
				drawBits(4, v);
				k = instrKind_t'(v % 13);
			end
			runInstr(k, ok);
			n++;
		end
		$display("Summary: %0d instructions, %0d value errors, %0d timeouts",
			n, valueErrors, timeouts);
		if (valueErrors == 0 && timeouts == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* src.f */
+incdir+sim
source/controlPkg.sv
source/instrDecoder.sv
source/controlSequencer.sv
source/controlWordTable.sv
source/multicycleControl.sv
sim/tbMulticycleControl.sv

/* build.sh */
#!/bin/bash
# Compile with Verilator, run, and pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module tbMulticycleControl -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
	&& exit 0 \
	|| exit 1
